//--- hw/rv_pkg.sv
package rv_pkg;

  // datapath and address width
  localparam int xlen = 32;
  localparam int reg_addr_w = 5;

  // major opcodes, inst[6:0]
  typedef enum logic [6:0] {
    op_load   = 7'b000_0011,
    op_imm    = 7'b001_0011,  // addi only, funct3 ignored
    op_auipc  = 7'b001_0111,
    op_store  = 7'b010_0011,
    op_lui    = 7'b011_0111,
    op_jalr   = 7'b110_0111,
    op_jal    = 7'b110_1111,
    op_system = 7'b111_0011   // ebreak and friends, all halt
  } opcode_e;

  // access size, same as funct3 of loads and stores
  typedef enum logic [2:0] {
    sz_b  = 3'b000,
    sz_h  = 3'b001,
    sz_w  = 3'b010,
    sz_bu = 3'b100,
    sz_hu = 3'b101
  } mem_size_e;

  // write-back source
  typedef enum logic [1:0] {
    wb_adder = 2'b00,  // shared adder result
    wb_link  = 2'b01,  // pc + 4
    wb_load  = 2'b10   // extended load data
  } wb_sel_e;

  // apb master phases
  typedef enum logic [1:0] {
    st_idle   = 2'b00,
    st_setup  = 2'b01,
    st_access = 2'b10
  } lsu_state_e;

endpackage

//--- hw/rv_decoder.sv
module rv_decoder (
  input  logic [31:0]                   inst,
  output logic [rv_pkg::reg_addr_w-1:0] rs1,
  output logic [rv_pkg::reg_addr_w-1:0] rs2,
  output logic [rv_pkg::reg_addr_w-1:0] rd,
  output logic [rv_pkg::xlen-1:0]       imm,
  output logic                          use_pc,
  output logic                          jump,
  output rv_pkg::wb_sel_e               wb_sel,
  output logic                          reg_we,
  output logic                          mem_req,
  output logic                          mem_write,
  output rv_pkg::mem_size_e             mem_size,
  output logic                          is_halt
);
  import rv_pkg::*;

  opcode_e          opcode;
  logic [xlen-1:0]  imm_i;
  logic [xlen-1:0]  imm_s;
  logic [xlen-1:0]  imm_u;
  logic [xlen-1:0]  imm_j;

  assign opcode = opcode_e'(inst[6:0]);

  // lui adds the immediate to x0, so force the rs1 index
  assign rs1 = (opcode == op_lui) ? '0 : inst[19:15];
  assign rs2 = inst[24:20];
  assign rd  = inst[11:7];

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_u = {inst[31:12], 12'h000};  // already shifted
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  assign mem_size = mem_size_e'(inst[14:12]);

  always_comb begin
    imm       = '0;
    use_pc    = 1'b0;
    jump      = 1'b0;
    wb_sel    = wb_adder;
    reg_we    = 1'b0;
    mem_req   = 1'b0;
    mem_write = 1'b0;
    is_halt   = 1'b0;
    case (opcode)
      op_imm: begin
        imm    = imm_i;
        reg_we = 1'b1;
      end
      op_lui: begin
        imm    = imm_u;
        reg_we = 1'b1;
      end
      op_auipc: begin
        imm    = imm_u;
        use_pc = 1'b1;
        reg_we = 1'b1;
      end
      op_jal: begin
        imm    = imm_j;
        use_pc = 1'b1;
        jump   = 1'b1;
        wb_sel = wb_link;
        reg_we = 1'b1;
      end
      op_jalr: begin
        imm    = imm_i;  // base is rs1
        jump   = 1'b1;
        wb_sel = wb_link;
        reg_we = 1'b1;
      end
      op_load: begin
        imm     = imm_i;
        wb_sel  = wb_load;
        reg_we  = 1'b1;
        mem_req = 1'b1;
      end
      op_store: begin
        imm       = imm_s;
        mem_req   = 1'b1;
        mem_write = 1'b1;
      end
      op_system: is_halt = 1'b1;
      default: ;  // branches, r-type and junk fall through as nops
    endcase
  end

endmodule

//--- hw/rv_regfile.sv
module rv_regfile (
  input  logic                          clk,
  input  logic                          we,
  input  logic [rv_pkg::reg_addr_w-1:0] waddr,
  input  logic [rv_pkg::xlen-1:0]       wdata,
  input  logic [rv_pkg::reg_addr_w-1:0] raddr1,
  input  logic [rv_pkg::reg_addr_w-1:0] raddr2,
  output logic [rv_pkg::xlen-1:0]       rdata1,
  output logic [rv_pkg::xlen-1:0]       rdata2
);
  import rv_pkg::*;

  logic [xlen-1:0] regs [2**reg_addr_w];

  always_ff @(posedge clk) begin
    if (we && waddr != '0) begin  // x0 never written
      regs[waddr] <= wdata;
    end
  end

  // async read, x0 reads as zero
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

//--- hw/rv_lsu.sv
module rv_lsu (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    req,
  input  logic                    write,
  input  rv_pkg::mem_size_e       size,
  input  logic [rv_pkg::xlen-1:0] addr,
  input  logic [rv_pkg::xlen-1:0] store_data,
  output logic                    done,
  output logic [rv_pkg::xlen-1:0] load_data,
  output logic [rv_pkg::xlen-1:0] paddr,
  output logic                    psel,
  output logic                    penable,
  output logic                    pwrite,
  output logic [rv_pkg::xlen-1:0] pwdata,
  output logic [3:0]              pstrb,
  input  logic [rv_pkg::xlen-1:0] prdata,
  input  logic                    pready
);
  import rv_pkg::*;

  lsu_state_e      state;
  logic            start;
  logic [1:0]      lane;
  logic [1:0]      lane_q;   // byte offset of the pending access
  mem_size_e       size_q;
  logic [xlen-1:0] wdata_lane;
  logic [3:0]      strb;
  logic [7:0]      rd_byte;
  logic [15:0]     rd_half;

  assign start = (state == st_idle) && req;
  assign lane  = addr[1:0];

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle:   if (req) state <= st_setup;
        st_setup:  state <= st_access;
        st_access: if (pready) state <= st_idle;
        default:   state <= st_idle;
      endcase
    end
  end

  assign psel    = (state != st_idle);
  assign penable = (state == st_access);
  assign done    = (state == st_access) && pready;

  // replicate the data so the addressed lane always carries it
  always_comb begin
    wdata_lane = '0;
    strb       = 4'b0000;
    case (size)
      sz_b: begin
        wdata_lane = {4{store_data[7:0]}};
        strb       = 4'b0001 << lane;
      end
      sz_h: begin
        wdata_lane = {2{store_data[15:0]}};
        if (!lane[0]) strb = lane[1] ? 4'b1100 : 4'b0011;
      end
      sz_w: begin
        wdata_lane = store_data;
        if (lane == 2'b00) strb = 4'b1111;
      end
      default: ;
    endcase
  end

  // captured once per transfer, held stable through access
  always_ff @(posedge clk) begin
    if (start) begin
      paddr  <= {addr[xlen-1:2], 2'b00};  // word aligned, lanes via pstrb
      pwrite <= write;
      pwdata <= write ? wdata_lane : '0;
      pstrb  <= write ? strb : 4'b0000;
      lane_q <= lane;
      size_q <= size;
    end
  end

  assign rd_byte = prdata[8*lane_q +: 8];
  assign rd_half = lane_q[1] ? prdata[31:16] : prdata[15:0];

  always_comb begin
    case (size_q)
      sz_b:  load_data = {{24{rd_byte[7]}}, rd_byte};
      sz_bu: load_data = {24'h000000, rd_byte};
      sz_h:  load_data = lane_q[0] ? '0 : {{16{rd_half[15]}}, rd_half};
      sz_hu: load_data = lane_q[0] ? '0 : {16'h0000, rd_half};
      sz_w:  load_data = (lane_q == 2'b00) ? prdata : '0;
      default: load_data = '0;  // unused funct3
    endcase
  end

endmodule

//--- hw/rv_core_top.sv
module rv_core_top #(
  parameter logic [rv_pkg::xlen-1:0] reset_pc = 32'h8000_0000
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [31:0]             inst,
  output logic [rv_pkg::xlen-1:0] pc,
  output logic                    halted,
  output logic [31:0]             paddr,
  output logic                    psel,
  output logic                    penable,
  output logic                    pwrite,
  output logic [31:0]             pwdata,
  output logic [3:0]              pstrb,
  input  logic [31:0]             prdata,
  input  logic                    pready
);
  import rv_pkg::*;

  logic [reg_addr_w-1:0] rs1, rs2, rd;
  logic [xlen-1:0]       imm;
  logic                  use_pc, jump, reg_we;
  logic                  mem_req, mem_write, is_halt;
  wb_sel_e               wb_sel;
  mem_size_e             mem_size;

  logic [xlen-1:0] rs1_data, rs2_data;
  logic [xlen-1:0] add_a, sum, target, snpc, next_pc, wb_data;
  logic [xlen-1:0] load_data;
  logic            lsu_done, is_jalr, advance;

  rv_decoder u_dec (
    .inst, .rs1, .rs2, .rd, .imm, .use_pc, .jump, .wb_sel,
    .reg_we, .mem_req, .mem_write, .mem_size, .is_halt
  );

  rv_regfile u_rf (
    .clk,
    .we     (reg_we && advance),  // commit only when the instruction retires
    .waddr  (rd),
    .wdata  (wb_data),
    .raddr1 (rs1),
    .raddr2 (rs2),
    .rdata1 (rs1_data),
    .rdata2 (rs2_data)
  );

  rv_lsu u_lsu (
    .clk, .rst,
    .req        (mem_req && !halted),
    .write      (mem_write),
    .size       (mem_size),
    .addr       (sum),
    .store_data (rs2_data),
    .done       (lsu_done),
    .load_data,
    .paddr, .psel, .penable, .pwrite, .pwdata, .pstrb, .prdata, .pready
  );

  // one adder serves addresses, jump targets and addi/lui/auipc
  assign is_jalr = (opcode_e'(inst[6:0]) == op_jalr);
  assign add_a   = use_pc ? pc : rs1_data;
  assign sum     = add_a + imm;
  assign target  = {sum[xlen-1:1], sum[0] & ~is_jalr};
  assign snpc    = pc + 32'd4;
  assign next_pc = jump ? target : snpc;

  always_comb begin
    case (wb_sel)
      wb_link: wb_data = snpc;
      wb_load: wb_data = load_data;
      default: wb_data = sum;
    endcase
  end

  // memory ops wait for the apb transfer, ebreak stops here
  assign advance = !halted && !is_halt && (!mem_req || lsu_done);

  always_ff @(posedge clk) begin
    if (rst) begin
      pc     <= reset_pc;
      halted <= 1'b0;
    end else begin
      if (advance) pc <= next_pc;
      if (is_halt) halted <= 1'b1;  // sticky until reset
    end
  end

endmodule

//--- testbench/core_tb.sv
module core_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [31:0] reset_pc = 32'h8000_0000;
  localparam logic [31:0] nop      = 32'h0000_0013;  // addi x0, x0, 0
  localparam logic [31:0] ebreak   = 32'h0010_0073;

  logic        clk, rst, halted, psel, penable, pwrite, pready;
  logic [31:0] inst, pc, paddr, pwdata, prdata;
  logic [3:0]  pstrb;

  logic [31:0] imem [64];
  logic [31:0] dmem [32];      // 128 byte window aliased over the bus
  int          prog_len, wait_cnt, errors, tests, failed;
  integer      seed = 56;
  logic [31:0] log_addr [$];
  logic [31:0] log_data [$];
  logic [3:0]  log_strb [$];
  logic [31:0] pc_trace [$];   // every new pc after release
  logic [31:0] pc_before, wmask;
  logic        hold;

  rv_core_top #(.reset_pc(reset_pc)) dut0 (
    .clk, .rst, .inst, .pc, .halted, .paddr, .psel, .penable,
    .pwrite, .pwdata, .pstrb, .prdata, .pready
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] itype(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] stype(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b010_0011};
  endfunction

  function automatic logic [31:0] utype(input logic [19:0] imm, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] jtype(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b110_1111};
  endfunction

  function automatic logic [31:0] fetch(input logic [31:0] addr);
    logic [31:0] off;
    off = addr - reset_pc;
    if (off < 32'd256) return imem[off[7:2]];
    return nop;  // unmapped
  endfunction

  // preload byte has its top bit set so sign extension shows
  function automatic logic [7:0] byte_at(input logic [31:0] a);
    return 8'h80 | {1'b0, a[6:0]};
  endfunction

  function automatic logic [31:0] expected_load(input logic [2:0] f3, input logic [31:0] a);
    logic [7:0]  b;
    logic [15:0] h;
    b = byte_at(a);
    h = {byte_at(a + 32'd1), b};
    case (f3)
      3'b000:  return 32'($signed(b));
      3'b100:  return {24'h0, b};
      3'b001:  return 32'($signed(h));
      3'b101:  return {16'h0, h};
      default: return {byte_at(a + 32'd3), byte_at(a + 32'd2), h};
    endcase
  endfunction

  // instruction side answers pc within the same cycle
  always @(posedge clk) begin
    #1;
    inst = fetch(pc);
  end

  // apb slave with 0..3 wait states per transfer
  always @(posedge clk) begin
    #1;
    if (psel && !penable) begin
      wait_cnt = {$random(seed)} % 4;
      pready = 1'b0;
    end else if (psel && penable) begin
      if (wait_cnt == 0) begin
        pready = 1'b1;
      end else begin
        wait_cnt = wait_cnt - 1;
        pready = 1'b0;
      end
    end else begin
      pready = 1'b0;
    end
    prdata = dmem[paddr[6:2]];
  end

  always @(posedge clk) begin
    if (!rst && psel && penable && pready && pwrite) begin
      for (int k = 0; k < 4; k++) begin
        wmask[8*k +: 8] = {8{pstrb[k]}};
        if (pstrb[k]) dmem[paddr[6:2]][8*k +: 8] = pwdata[8*k +: 8];
      end
      log_addr.push_back(paddr);
      log_data.push_back(pwdata & wmask);  // only the enabled lanes count
      log_strb.push_back(pstrb);
    end
  end

  // record each new pc and hold pc while a transfer is open
  always @(posedge clk) begin
    pc_before = pc;
    hold = psel && !(penable && pready);
    #1;
    if (!rst) begin
      if (hold) begin
        assert (pc === pc_before)
        else begin
          $display("Mismatch pc during apb wait: got %h expected %h", pc, pc_before);
          errors++;
        end
      end
      if (pc !== pc_before) pc_trace.push_back(pc);
    end
  end

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
    else begin
      $display("Mismatch %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_write(input int k, input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
    assert (k < log_addr.size())
    else begin
      $display("apb write %0d never happened", k);
      errors++;
    end
    if (k < log_addr.size()) begin
      check_val("paddr", log_addr[k], addr);
      check_val("pwdata", log_data[k], data);
      check_val("pstrb", 32'(log_strb[k]), 32'(strb));
    end
  endtask

  task automatic new_program();
    for (int i = 0; i < 64; i++) imem[i] = nop;
    prog_len = 0;
  endtask

  task automatic emit(input logic [31:0] word);
    imem[prog_len] = word;
    prog_len++;
  endtask

  task automatic hold_reset();
    rst = 1'b1;
    repeat (16) @(posedge clk);
    #1;
    for (int i = 0; i < 32; i++) begin
      for (int k = 0; k < 4; k++) dmem[i][8*k +: 8] = byte_at(32'(4*i + k));
    end
    log_addr.delete();
    log_data.delete();
    log_strb.delete();
    pc_trace.delete();
  endtask

  task automatic wait_halt();
    int n = 0;
    while (!halted && n < 500) begin
      @(posedge clk);
      #1;
      n++;
    end
    assert (halted)
    else begin
      $display("timeout, core did not halt within 500 cycles");
      errors++;
    end
  endtask

  task automatic run_program();
    hold_reset();
    rst = 1'b0;
    wait_halt();
  endtask

  task automatic report(input string name, input int err0);
    tests++;
    if (errors == err0) begin
      $display("test %s passed", name);
    end else begin
      failed++;
      $display("test %s failed with %0d errors", name, errors - err0);
    end
  endtask

  task automatic reset_test();
    int err0 = errors;
    new_program();
    emit(ebreak);
    hold_reset();
    check_val("pc", pc, reset_pc);
    check_val("halted", 32'(halted), 32'd0);
    check_val("psel", 32'(psel), 32'd0);
    check_val("penable", 32'(penable), 32'd0);
    rst = 1'b0;
    #2;  // first cycle out of reset
    check_val("pc", pc, reset_pc);
    check_val("halted", 32'(halted), 32'd0);
    check_val("psel", 32'(psel), 32'd0);
    check_val("penable", 32'(penable), 32'd0);
    wait_halt();
    check_val("pc", pc, reset_pc);
    report("reset", err0);
  endtask

  task automatic store_word_test();
    int err0 = errors;
    logic [31:0] exp_word;
    exp_word = (32'h12345 << 12) + 32'($signed(12'hedd));
    new_program();
    emit(utype(20'h12345, 5'd1, 7'h37));               // lui x1
    emit(itype(12'hedd, 5'd1, 3'b000, 5'd1, 7'h13));   // addi x1, x1, -0x123
    emit(utype(20'h00001, 5'd2, 7'h37));               // x2 = 0x1000
    emit(stype(12'h010, 5'd1, 5'd2, 3'b010));
    emit(ebreak);
    run_program();
    check_write(0, 32'h0000_1010, exp_word, 4'hf);
    check_val("write count", 32'(log_addr.size()), 32'd1);
    check_val("pc steps", 32'(pc_trace.size()), 32'd4);
    for (int i = 0; i < 4; i++) check_val("pc", pc_trace[i], reset_pc + 32'(4*(i+1)));
    report("store_word", err0);
  endtask

  task automatic store_lane_test();
    int err0 = errors;
    new_program();
    emit(utype(20'h00001, 5'd1, 7'h37));
    emit(utype(20'ha1b2c, 5'd2, 7'h37));
    emit(itype(12'h3d4, 5'd2, 3'b000, 5'd2, 7'h13));   // x2 = 0xa1b2c3d4
    for (int k = 0; k < 4; k++) emit(stype(12'(32 + k), 5'd2, 5'd1, 3'b000));
    emit(stype(12'h024, 5'd2, 5'd1, 3'b001));
    emit(stype(12'h026, 5'd2, 5'd1, 3'b001));
    emit(ebreak);
    run_program();
    for (int k = 0; k < 4; k++) check_write(k, 32'h1020, 32'hd4 << (8*k), 4'b0001 << k);
    check_write(4, 32'h1024, 32'h0000_c3d4, 4'b0011);
    check_write(5, 32'h1024, 32'hc3d4_0000, 4'b1100);
    report("store_lane", err0);
  endtask

  task automatic load_test();
    int err0 = errors;
    logic [11:0] offs [5] = '{12'd5, 12'd3, 12'd6, 12'd4, 12'd8};
    logic [2:0]  f3s [5]  = '{3'b000, 3'b100, 3'b001, 3'b101, 3'b010};  // lb lbu lh lhu lw
    new_program();
    emit(utype(20'h00001, 5'd1, 7'h37));
    for (int i = 0; i < 5; i++) begin
      emit(itype(offs[i], 5'd1, f3s[i], 5'd3, 7'h03));
      emit(stype(12'(96 + 4*i), 5'd3, 5'd1, 3'b010));  // dump x3 to 0x1060 + 4i
    end
    emit(ebreak);
    run_program();
    for (int i = 0; i < 5; i++) begin
      check_write(i, 32'h1060 + 32'(4*i), expected_load(f3s[i], 32'h1000 + 32'(offs[i])),
                  4'hf);
    end
    report("load", err0);
  endtask

  task automatic jump_test();
    int err0 = errors;
    logic [31:0] jal_pc, auipc_pc, jalr_pc;
    jal_pc   = reset_pc + 32'd4;
    auipc_pc = reset_pc + 32'd20;
    jalr_pc  = reset_pc + 32'd32;
    new_program();
    emit(utype(20'h00001, 5'd1, 7'h37));
    emit(jtype(21'd12, 5'd2));                         // skips two nops
    emit(nop);
    emit(nop);
    emit(stype(12'h040, 5'd2, 5'd1, 3'b010));
    emit(utype(20'h00002, 5'd3, 7'h17));
    emit(stype(12'h044, 5'd3, 5'd1, 3'b010));
    emit(utype(20'h00000, 5'd4, 7'h17));               // x4 = own pc
    emit(itype(12'h015, 5'd4, 3'b000, 5'd5, 7'h67));   // bit 0 of the odd sum is dropped
    emit(nop);
    emit(nop);
    emit(nop);
    emit(stype(12'h048, 5'd5, 5'd1, 3'b010));
    emit(ebreak);
    run_program();
    check_write(0, 32'h1040, jal_pc + 32'd4, 4'hf);
    check_write(1, 32'h1044, auipc_pc + (32'h2 << 12), 4'hf);
    check_write(2, 32'h1048, jalr_pc + 32'd4, 4'hf);
    check_val("jal target", pc_trace[1], jal_pc + 32'd12);
    check_val("jalr target", pc_trace[6], (jalr_pc - 32'd4 + 32'h15) & ~32'h1);
    report("jump", err0);
  endtask

  task automatic halt_test();
    int err0 = errors;
    new_program();
    emit(utype(20'h00001, 5'd1, 7'h37));
    emit(utype(20'h5a5a5, 5'd8, 7'h37));
    emit(32'h0000_0463);  // beq x0, x0, +8 with x8 in the rd field
    emit(stype(12'h050, 5'd8, 5'd1, 3'b010));
    emit(ebreak);
    run_program();
    check_val("pc steps", 32'(pc_trace.size()), 32'd4);
    for (int i = 0; i < 4; i++) check_val("pc", pc_trace[i], reset_pc + 32'(4*(i+1)));
    check_val("write count", 32'(log_addr.size()), 32'd1);
    check_write(0, 32'h1050, 32'h5a5a5 << 12, 4'hf);
    repeat (20) begin
      @(posedge clk);
      #1;
      check_val("pc", pc, reset_pc + 32'd16);
      check_val("psel", 32'(psel), 32'd0);
      check_val("halted", 32'(halted), 32'd1);
    end
    report("halt", err0);
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    inst = nop;
    prdata = '0;
    pready = 1'b0;
    wait_cnt = 0;
    errors = 0;
    tests = 0;
    failed = 0;
    new_program();
    reset_test();
    store_word_test();
    store_lane_test();
    load_test();
    jump_test();
    halt_test();
    $display("%0d tests run, %0d failed, %0d errors", tests, failed, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- all.f
hw/rv_pkg.sv
hw/rv_decoder.sv
hw/rv_regfile.sv
hw/rv_lsu.sv
hw/rv_core_top.sv
testbench/core_tb.sv

//--- run.sh
#!/bin/sh
# build and run the core testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f all.f --top-module core_tb

out=$(./obj_dir/Vcore_tb)
printf '%s\n' "$out"

# exit status follows the pass line
printf '%s\n' "$out" | grep -qx '>>> PASS'
